// File: flist.f
source/hazardPkg.sv
source/pipeStage.sv
source/forwardUnit.sv
source/stallUnit.sv
source/hazardControl.sv
source/hazardTop.sv
tests/hazardTop_assert.sv
tests/hazardTb.sv

// File: run.sh
#!/bin/sh
# Builds the hazard testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f flist.f --top-module hazardTb \
    -Mdir "$buildDir" -o hazardSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$buildDir/hazardSim" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$logFile"; then
    echo "Testbench reported a failure, see $logFile"
    exit 1
fi
if ! grep -q "Verification passed" "$logFile"; then
    echo "No result line found in $logFile"
    exit 1
fi
exit 0

// File: source/forwardUnit.sv
`timescale 1ns/1ps

// Forwarding select logic for the execute operands and the
// decode-stage branch comparator.
module forwardUnit (
    input  hazardPkg::decodeEntryT decodeIn,
    input  hazardPkg::decodeEntryT execEntry,
    input  hazardPkg::destEntryT   memEntry,
    input  hazardPkg::destEntryT   wbEntry,
    output hazardPkg::fwdSelT      forwardAE,
    output hazardPkg::fwdSelT      forwardBE,
    output logic                   forwardAD,
    output logic                   forwardBD
);

    // Memory is checked first since it holds the newer result.
    function automatic hazardPkg::fwdSelT execSelect(
        input hazardPkg::regIdxT    src,
        input hazardPkg::destEntryT memDest,
        input hazardPkg::destEntryT wbDest
    );
        hazardPkg::fwdSelT sel;
        sel = hazardPkg::fwdNone;
        if (memDest.regWrite && (memDest.rd != '0) && (memDest.rd == src)) begin
            sel = hazardPkg::fwdMemory;
        end else if (wbDest.regWrite && (wbDest.rd != '0) && (wbDest.rd == src)) begin
            sel = hazardPkg::fwdWriteback;
        end
        return sel;
    endfunction

    // A load in memory has no data yet, so the branch must wait for it
    // instead of forwarding.
    function automatic logic decodeSelect(
        input hazardPkg::regIdxT    src,
        input hazardPkg::destEntryT memDest,
        input logic                 isBranch
    );
        logic hit;
        hit = memDest.regWrite && !memDest.memRead
            && (memDest.rd != '0) && (memDest.rd == src);
        return isBranch && hit;
    endfunction

    logic branchD;

    assign branchD = decodeIn.valid && decodeIn.branch;

    always_comb begin
        forwardAE = execSelect(execEntry.rs1, memEntry, wbEntry);
        forwardBE = execSelect(execEntry.rs2, memEntry, wbEntry);
    end

    always_comb begin
        forwardAD = decodeSelect(decodeIn.rs1, memEntry, branchD);
        forwardBD = decodeSelect(decodeIn.rs2, memEntry, branchD);
    end

endmodule

// File: source/hazardControl.sv
`timescale 1ns/1ps

// Turns the hazard causes into stall and flush levels and
// the per-stage controls.
module hazardControl (
    input  logic                 loadUse,
    input  logic                 branchHazard,
    input  logic                 flushBranch,
    output hazardPkg::stageCtrlT stageCtrl,
    output logic                 stall,
    output logic                 flush
);

    // Either cause holds the decode instruction in place.
    assign stall = loadUse || branchHazard;

    // A stall leaves an empty slot in execute, just like a mispredict.
    assign flush = stall || flushBranch;

    // flushD wins over stallD upstream.
    // After a mispredict the held instruction is on the wrong path.
    always_comb begin
        stageCtrl.stallD  = stall;
        stageCtrl.bubbleE = flush;
        stageCtrl.flushD  = flushBranch;
    end

endmodule

// File: source/hazardPkg.sv
package hazardPkg;

    // Width of a register index for 32 architectural registers.
    localparam int regIdxWidth = 5;

    typedef logic [regIdxWidth-1:0] regIdxT;

    // Decoded instruction fields seen by the hazard logic.
    // The execute stage carries the same entry one cycle later.
    typedef struct packed {
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        logic   regWrite;
        logic   memRead;
        logic   branch;
        logic   valid;
    } decodeEntryT;

    // Destination fields only, for the memory and writeback stages.
    typedef struct packed {
        regIdxT rd;
        logic   regWrite;
        logic   memRead;
    } destEntryT;

    // Operand source select for the execute stage muxes.
    typedef enum logic [1:0] {
        fwdNone      = 2'b00,
        fwdWriteback = 2'b01,
        fwdMemory    = 2'b10
    } fwdSelT;

    // Per-cycle stage controls.
    typedef struct packed {
        logic stallD;
        logic bubbleE;
        logic flushD;
    } stageCtrlT;

endpackage

// File: source/hazardTop.sv
`timescale 1ns/1ps

// Hazard subsystem top level.
// Tracks the instructions in execute, memory and writeback and
// produces the forwarding selects and stall and flush levels.
module hazardTop #(
    parameter int regIdxWidth = 5
)(
    input  logic                   clk,
    input  logic                   rstN,
    input  hazardPkg::decodeEntryT decodeIn,
    input  logic                   flushBranch,
    output hazardPkg::fwdSelT      forwardAE,
    output hazardPkg::fwdSelT      forwardBE,
    output logic                   forwardAD,
    output logic                   forwardBD,
    output logic                   stall,
    output logic                   flush
);

    hazardPkg::decodeEntryT execEntry;
    hazardPkg::destEntryT   execDest;
    hazardPkg::destEntryT   memEntry;
    hazardPkg::destEntryT   wbEntry;
    hazardPkg::stageCtrlT   stageCtrl;
    logic                   loadUse;
    logic                   branchHazard;

    // The stage entries are sized by the package, so the width must agree.
    if (regIdxWidth != hazardPkg::regIdxWidth) begin : gWidthCheck
        $error("hazardTop regIdxWidth does not match hazardPkg");
    end

    // Only the destination fields travel past execute.
    assign execDest = '{
        rd:       execEntry.rd,
        regWrite: execEntry.regWrite,
        memRead:  execEntry.memRead
    };

    pipeStage #(.payloadT(hazardPkg::decodeEntryT)) execStage (
        .clk    (clk),
        .rstN   (rstN),
        .bubble (stageCtrl.bubbleE),
        .d      (decodeIn),
        .q      (execEntry)
    );

    // Memory and writeback never stall.
    pipeStage #(.payloadT(hazardPkg::destEntryT)) memStage (
        .clk    (clk),
        .rstN   (rstN),
        .bubble (1'b0),
        .d      (execDest),
        .q      (memEntry)
    );

    pipeStage #(.payloadT(hazardPkg::destEntryT)) wbStage (
        .clk    (clk),
        .rstN   (rstN),
        .bubble (1'b0),
        .d      (memEntry),
        .q      (wbEntry)
    );

    forwardUnit forwarding (
        .decodeIn  (decodeIn),
        .execEntry (execEntry),
        .memEntry  (memEntry),
        .wbEntry   (wbEntry),
        .forwardAE (forwardAE),
        .forwardBE (forwardBE),
        .forwardAD (forwardAD),
        .forwardBD (forwardBD)
    );

    stallUnit stallDetect (
        .decodeIn     (decodeIn),
        .execEntry    (execEntry),
        .memEntry     (memEntry),
        .loadUse      (loadUse),
        .branchHazard (branchHazard)
    );

    hazardControl control (
        .loadUse      (loadUse),
        .branchHazard (branchHazard),
        .flushBranch  (flushBranch),
        .stageCtrl    (stageCtrl),
        .stall        (stall),
        .flush        (flush)
    );

endmodule

// File: source/pipeStage.sv
`timescale 1ns/1ps

// Generic stage register.
// A bubble loads an all-zero entry, which is an invalid instruction
// that writes no register.
module pipeStage #(
    parameter type payloadT = logic
)(
    input  logic    clk,
    input  logic    rstN,
    input  logic    bubble,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= '0;
        end else if (bubble) begin
            // Insert a bubble in place of the incoming entry.
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: source/stallUnit.sv
`timescale 1ns/1ps

// Stall detection for the decode stage.
module stallUnit (
    input  hazardPkg::decodeEntryT decodeIn,
    input  hazardPkg::decodeEntryT execEntry,
    input  hazardPkg::destEntryT   memEntry,
    output logic                   loadUse,
    output logic                   branchHazard
);

    logic execRs1Match;
    logic execRs2Match;
    logic memRs1Match;
    logic memRs2Match;
    logic execWrites;
    logic memLoads;
    logic branchD;

    // Source matches against a nonzero destination.
    assign execRs1Match = (execEntry.rd != '0) && (execEntry.rd == decodeIn.rs1);
    assign execRs2Match = (execEntry.rd != '0) && (execEntry.rd == decodeIn.rs2);
    assign memRs1Match  = (memEntry.rd != '0) && (memEntry.rd == decodeIn.rs1);
    assign memRs2Match  = (memEntry.rd != '0) && (memEntry.rd == decodeIn.rs2);

    assign execWrites = execEntry.regWrite;
    assign memLoads   = memEntry.regWrite && memEntry.memRead;
    assign branchD    = decodeIn.valid && decodeIn.branch;

    // Load data arrives one cycle too late for execute.
    assign loadUse = decodeIn.valid && execEntry.memRead
        && (execRs1Match || execRs2Match);

    // The branch compares in decode, so it waits for an ALU result still
    // in execute, and for a load until it reaches writeback.
    always_comb begin
        branchHazard = 1'b0;
        if (branchD) begin
            if (execWrites && (execRs1Match || execRs2Match)) begin
                branchHazard = 1'b1;
            end
            if (memLoads && (memRs1Match || memRs2Match)) begin
                branchHazard = 1'b1;
            end
        end
    end

endmodule

// File: tests/hazardStimulus.txt
# test rs1 rs2 rd regWrite memRead branch valid flushBranch fwdAE fwdBE fwdAD fwdBD stall flush
# fwdAE and fwdBE codes: 0 none, 1 writeback, 2 memory.
# Test 1: all outputs stay zero after reset.
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 3 4 5 1 0 0 1 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# Test 2: ALU forwarding from memory and writeback, memory wins, x0 never forwards.
2 1 2 5 1 0 0 1 0 0 0 0 0 0 0
2 5 6 7 1 0 0 1 0 0 0 0 0 0 0
2 8 5 9 1 0 0 1 0 2 0 0 0 0 0
2 7 7 10 1 0 0 1 0 0 1 0 0 0 0
2 3 4 12 1 0 0 1 0 1 1 0 0 0 0
2 1 1 12 1 0 0 1 0 0 0 0 0 0 0
2 12 12 13 1 0 0 1 0 0 0 0 0 0 0
2 2 3 0 1 0 0 1 0 2 2 0 0 0 0
2 0 0 14 1 0 0 1 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# Test 3: load-use stalls one cycle, the held instruction then takes the load from writeback.
3 1 0 6 1 1 0 1 0 0 0 0 0 0 0
3 6 2 7 1 0 0 1 0 0 0 0 0 1 1
3 6 2 7 1 0 0 1 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 1 0 0 0 0 0
3 1 0 0 1 1 0 1 0 0 0 0 0 0 0
3 0 0 8 1 0 0 1 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 2 0 9 1 1 0 1 0 0 0 0 0 0 0
3 3 9 10 1 0 0 1 0 0 0 0 0 1 1
3 3 9 10 1 0 0 1 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 1 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# Test 4: branch on an ALU result stalls once, branch on a load stalls twice.
4 1 2 5 1 0 0 1 0 0 0 0 0 0 0
4 5 3 0 0 0 1 1 0 0 0 0 0 1 1
4 5 3 0 0 0 1 1 0 0 0 1 0 0 0
4 0 0 0 0 0 0 0 0 1 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 1 0 6 1 1 0 1 0 0 0 0 0 0 0
4 4 6 0 0 0 1 1 0 0 0 0 0 1 1
4 4 6 0 0 0 1 1 0 0 0 0 0 1 1
4 4 6 0 0 0 1 1 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# Test 5: a mispredict flushes the decode slot, also while a load-use stall is pending.
5 1 2 5 1 0 0 1 0 0 0 0 0 0 0
5 3 4 8 1 0 0 1 1 0 0 0 0 0 1
5 8 5 9 1 0 0 1 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 1 0 0 0 0
5 1 0 6 1 1 0 1 0 0 0 0 0 0 0
5 6 0 7 1 0 0 1 1 0 0 0 0 1 1
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# Test 6: mixed sequence of load-use, branch stalls, a mispredict and forwarding.
6 1 0 10 1 1 0 1 0 0 0 0 0 0 0
6 10 2 11 1 0 0 1 0 0 0 0 0 1 1
6 10 2 11 1 0 0 1 0 0 0 0 0 0 0
6 11 10 0 0 0 1 1 0 1 0 0 0 1 1
6 11 10 0 0 0 1 1 0 0 0 1 0 0 0
6 11 11 12 1 0 0 1 1 1 0 0 0 0 1
6 12 11 13 1 0 0 1 0 0 0 0 0 0 0
6 13 13 11 1 0 0 1 0 0 0 0 0 0 0
6 11 13 0 0 0 1 1 0 2 2 0 1 1 1
6 11 13 0 0 0 1 1 0 0 0 1 0 0 0
6 0 0 0 0 0 0 0 0 1 0 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: tests/hazardTb.sv
`timescale 1ns/1ps

// Testbench for the hazard subsystem.
// Each stimulus line is one cycle of decode inputs and expected outputs.
module hazardTb;

    localparam int    clkPeriod  = 100;
    localparam int    checkDelay = 10;
    localparam string stimFile   = "tests/hazardStimulus.txt";

    // One cycle of stimulus with its expected outputs.
    typedef struct packed {
        logic [15:0]            testNum;
        hazardPkg::decodeEntryT decode;
        logic                   flushBranch;
        logic [1:0]             expAE;
        logic [1:0]             expBE;
        logic                   expAD;
        logic                   expBD;
        logic                   expStall;
        logic                   expFlush;
    } vectorT;

    logic                   clk;
    logic                   rstN;
    hazardPkg::decodeEntryT decodeIn;
    logic                   flushBranch;
    hazardPkg::fwdSelT      forwardAE;
    hazardPkg::fwdSelT      forwardBE;
    logic                   forwardAD;
    logic                   forwardBD;
    logic                   stall;
    logic                   flush;

    vectorT      vectors[$];
    logic [15:0] curTest;
    int          errorCount  = 0;
    int          checkCount  = 0;
    int          testErrors  = 0;
    int          testCycles  = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          cycleCount  = 0;
    int          cycleLimit  = 0;

    hazardTop #(.regIdxWidth(hazardPkg::regIdxWidth)) dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .decodeIn    (decodeIn),
        .flushBranch (flushBranch),
        .forwardAE   (forwardAE),
        .forwardBE   (forwardBE),
        .forwardAD   (forwardAD),
        .forwardBD   (forwardBD),
        .stall       (stall),
        .flush       (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Watchdog with a limit set once the stimulus is loaded.
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if ((cycleLimit > 0) && (cycleCount > cycleLimit)) begin
            $display("Simulation timed out after %0d cycles", cycleLimit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("ERR %0d ns: test %0d %s is %0d, expected %0d",
                $time, curTest, name, actual, expected);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportTest(input logic [15:0] testNum);
        if (testErrors == 0) begin
            testsPassed++;
            $display("Test %0d passed in %0d cycles", testNum, testCycles);
        end else begin
            testsFailed++;
            $display("Test %0d failed with %0d errors in %0d cycles",
                testNum, testErrors, testCycles);
        end
    endtask

    // Lines starting with # are comments.
    task automatic readStimulus();
        int     fd;
        int     n;
        int     f[15];
        string  line;
        vectorT vec;
        fd = $fopen(stimFile, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", stimFile);
            errorCount++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n == 15) begin
                vec.testNum         = f[0][15:0];
                vec.decode.rs1      = hazardPkg::regIdxT'(f[1]);
                vec.decode.rs2      = hazardPkg::regIdxT'(f[2]);
                vec.decode.rd       = hazardPkg::regIdxT'(f[3]);
                vec.decode.regWrite = f[4][0];
                vec.decode.memRead  = f[5][0];
                vec.decode.branch   = f[6][0];
                vec.decode.valid    = f[7][0];
                vec.flushBranch     = f[8][0];
                vec.expAE           = f[9][1:0];
                vec.expBE           = f[10][1:0];
                vec.expAD           = f[11][0];
                vec.expBD           = f[12][0];
                vec.expStall        = f[13][0];
                vec.expFlush        = f[14][0];
                vectors.push_back(vec);
            end else if (n > 0) begin
                $display("Malformed stimulus line: %s", line);
                errorCount++;
            end
        end
        $fclose(fd);
    endtask

    initial begin : stimulus
        vectorT vec;
        vectorT prevVec;
        int     i;
        rstN        = 1'b0;
        decodeIn    = '0;
        flushBranch = 1'b0;
        curTest     = '0;
        prevVec     = '0;
        readStimulus();
        if (vectors.size() == 0) begin
            $display("No stimulus lines were read");
            errorCount++;
        end
        cycleLimit = 2 * vectors.size() + 20;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (i = 0; i < vectors.size(); i++) begin
            vec = vectors[i];
            if ((i > 0) && (vec.testNum != curTest)) begin
                reportTest(curTest);
            end
            if ((i == 0) || (vec.testNum != curTest)) begin
                curTest    = vec.testNum;
                testErrors = 0;
                testCycles = 0;
            end
            // The decode slot must not change while it is stalled.
            if ((i > 0) && prevVec.expStall && !prevVec.flushBranch
                && (vec.decode != prevVec.decode)) begin
                $display("Stimulus vector %0d changes decodeIn during a stall", i + 1);
                errorCount++;
                testErrors++;
            end

            decodeIn    = vec.decode;
            flushBranch = vec.flushBranch;
            #checkDelay;
            checkValue("forwardAE", 32'(forwardAE), 32'(vec.expAE));
            checkValue("forwardBE", 32'(forwardBE), 32'(vec.expBE));
            checkValue("forwardAD", 32'(forwardAD), 32'(vec.expAD));
            checkValue("forwardBD", 32'(forwardBD), 32'(vec.expBD));
            checkValue("stall", 32'(stall), 32'(vec.expStall));
            checkValue("flush", 32'(flush), 32'(vec.expFlush));
            testCycles++;
            prevVec = vec;
            @(negedge clk);
        end
        if (vectors.size() > 0) begin
            reportTest(curTest);
        end

        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
            testsPassed, testsFailed, checkCount, errorCount);
        if ((errorCount == 0) && (testsFailed == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tests/hazardTop_assert.sv
`timescale 1ns/1ps

// Concurrent checks on the hazard subsystem, bound into hazardTop.
module hazardTopAssert (
    input logic                   clk,
    input logic                   rstN,
    input hazardPkg::decodeEntryT decodeIn,
    input hazardPkg::decodeEntryT execEntry,
    input hazardPkg::stageCtrlT   stageCtrl,
    input hazardPkg::fwdSelT      forwardAE,
    input hazardPkg::fwdSelT      forwardBE,
    input logic                   forwardAD,
    input logic                   forwardBD,
    input logic                   stall
);

    // A stall always empties the execute slot.
    stallFlush: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> (execEntry == '0))
        else $error("execute entry not cleared after a stall");

    // Register zero is never forwarded.
    execZeroSrc: assert property (@(posedge clk) disable iff (!rstN)
        ((forwardAE == hazardPkg::fwdNone) || (execEntry.rs1 != '0))
        && ((forwardBE == hazardPkg::fwdNone) || (execEntry.rs2 != '0)))
        else $error("execute forwarding selected for source register zero");

    decodeZeroSrc: assert property (@(posedge clk) disable iff (!rstN)
        (!forwardAD || (decodeIn.rs1 != '0)) && (!forwardBD || (decodeIn.rs2 != '0)))
        else $error("decode forwarding selected for source register zero");

    // A bubble leaves an all-zero execute entry.
    bubbleClears: assert property (@(posedge clk) disable iff (!rstN)
        stageCtrl.bubbleE |=> (execEntry == '0))
        else $error("execute entry not cleared after a bubble");

endmodule

bind hazardTop hazardTopAssert assertChecks (
    .clk       (clk),
    .rstN      (rstN),
    .decodeIn  (decodeIn),
    .execEntry (execEntry),
    .stageCtrl (stageCtrl),
    .forwardAE (forwardAE),
    .forwardBE (forwardBE),
    .forwardAD (forwardAD),
    .forwardBD (forwardBD),
    .stall     (stall)
);
